/* run.sh */
#!/bin/sh
# Build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module cpu_tb \
    -Mdir build -o cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./build/cpu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0

/* source/alu.sv */
`default_nettype none

module alu (
    input  lc3b_pkg::lc3b_aluop aluop,
    input  lc3b_pkg::lc3b_word  a,
    input  lc3b_pkg::lc3b_word  b,
    output lc3b_pkg::lc3b_word  f
);

    // Shift amount comes from imm4
    logic [3:0] shamt;

    assign shamt = b[3:0];

    always_comb begin
        case (aluop)
            lc3b_pkg::alu_add: f = a + b;
            lc3b_pkg::alu_and: f = a & b;
            lc3b_pkg::alu_not: f = ~a;
            lc3b_pkg::alu_sll: f = a << shamt;
            lc3b_pkg::alu_srl: f = a >> shamt;
            lc3b_pkg::alu_sra: f = lc3b_pkg::lc3b_word'($signed(a) >>> shamt);
            // alu_pass and the spare code
            default:           f = b;
        endcase
    end

endmodule

`default_nettype wire

/* source/cc_unit.sv */
`default_nettype none

module cc_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  lc3b_pkg::lc3b_word value,
    input  lc3b_pkg::lc3b_nzp  br_cond,
    output logic               br_enable
);

    lc3b_pkg::lc3b_nzp gen_cc;
    lc3b_pkg::lc3b_nzp cc;

    always_comb begin
        if ($signed(value) < 0) begin
            gen_cc = 3'b100;
        end else if (value == '0) begin
            gen_cc = 3'b010;
        end else begin
            gen_cc = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc <= '0;
        end else if (load) begin
            cc <= gen_cc;
        end
    end

    // Taken when any requested condition is currently set
    assign br_enable = |(br_cond & cc);

endmodule

`default_nettype wire

/* source/cpu.sv */
`default_nettype none

module cpu (
    input  logic               clk,
    input  logic               rst_n,
    input  lc3b_pkg::lc3b_word i_mem_rdata,
    output lc3b_pkg::lc3b_word i_mem_address,
    input  lc3b_pkg::lc3b_word d_mem_rdata,
    output lc3b_pkg::lc3b_word d_mem_address,
    output lc3b_pkg::lc3b_word d_mem_wdata,
    output logic               d_mem_read,
    output logic               d_mem_write
);

    lc3b_pkg::lc3b_control_word cw;
    lc3b_pkg::lc3b_opcode opcode;
    logic ir_4;
    logic ir_5;
    logic ir_11;

    // Decode happens in ID, same cycle
    cpu_control control_i (
        .opcode (opcode),
        .ir_4   (ir_4),
        .ir_5   (ir_5),
        .ir_11  (ir_11),
        .cw     (cw)
    );

    cpu_datapath datapath_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cw            (cw),
        .opcode        (opcode),
        .ir_4          (ir_4),
        .ir_5          (ir_5),
        .ir_11         (ir_11),
        .i_mem_rdata   (i_mem_rdata),
        .i_mem_address (i_mem_address),
        .d_mem_rdata   (d_mem_rdata),
        .d_mem_address (d_mem_address),
        .d_mem_wdata   (d_mem_wdata),
        .d_mem_read    (d_mem_read),
        .d_mem_write   (d_mem_write)
    );

endmodule

`default_nettype wire

/* source/cpu_control.sv */
`default_nettype none

module cpu_control (
    input  lc3b_pkg::lc3b_opcode       opcode,
    input  logic                       ir_4,
    input  logic                       ir_5,
    input  logic                       ir_11,
    output lc3b_pkg::lc3b_control_word cw
);

    always_comb begin
        // Everything inactive unless the opcode says otherwise
        cw = '0;
        case (opcode)
            lc3b_pkg::op_add: begin
                cw.ex.aluop = lc3b_pkg::alu_add;
                cw.ex.alumux_sel = ir_5 ? lc3b_pkg::alumux_imm5 : lc3b_pkg::alumux_reg;
                cw.wb.load_regfile = 1'b1;
                cw.wb.load_cc = 1'b1;
            end
            lc3b_pkg::op_and: begin
                cw.ex.aluop = lc3b_pkg::alu_and;
                cw.ex.alumux_sel = ir_5 ? lc3b_pkg::alumux_imm5 : lc3b_pkg::alumux_reg;
                cw.wb.load_regfile = 1'b1;
                cw.wb.load_cc = 1'b1;
            end
            lc3b_pkg::op_not: begin
                cw.ex.aluop = lc3b_pkg::alu_not;
                cw.wb.load_regfile = 1'b1;
                cw.wb.load_cc = 1'b1;
            end
            lc3b_pkg::op_shf: begin
                // Bit 4 is the direction, bit 5 arithmetic on right shifts
                case ({ir_5, ir_4})
                    2'b01:   cw.ex.aluop = lc3b_pkg::alu_srl;
                    2'b11:   cw.ex.aluop = lc3b_pkg::alu_sra;
                    default: cw.ex.aluop = lc3b_pkg::alu_sll;
                endcase
                cw.ex.shamt_sel = 1'b1;
                cw.wb.load_regfile = 1'b1;
                cw.wb.load_cc = 1'b1;
            end
            lc3b_pkg::op_ldr: begin
                cw.ex.aluop = lc3b_pkg::alu_add;
                cw.ex.alumux_sel = lc3b_pkg::alumux_off6;
                cw.mem.d_mem_read = 1'b1;
                cw.wb.load_regfile = 1'b1;
                cw.wb.load_cc = 1'b1;
                cw.wb.regfilemux_sel = lc3b_pkg::rfmux_mem;
            end
            lc3b_pkg::op_str: begin
                cw.ex.aluop = lc3b_pkg::alu_add;
                cw.ex.alumux_sel = lc3b_pkg::alumux_off6;
                cw.mem.d_mem_write = 1'b1;
            end
            lc3b_pkg::op_lea: begin
                cw.wb.load_regfile = 1'b1;
                cw.wb.regfilemux_sel = lc3b_pkg::rfmux_pc_off;
                cw.wb.addrmux_sel = lc3b_pkg::addr_off9;
            end
            lc3b_pkg::op_br: begin
                // nzp = 000 never matches, so 0x0000 falls through as a NOP
                cw.wb.branch = 1'b1;
                cw.wb.addrmux_sel = lc3b_pkg::addr_off9;
            end
            lc3b_pkg::op_jsr: begin
                // Only the offset select is decoded, no link or jump happens
                cw.wb.addrmux_sel = ir_11 ? lc3b_pkg::addr_off11 : lc3b_pkg::addr_off9;
            end
            default: begin
                cw = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/cpu_datapath.sv */
`default_nettype none
`include "lc3b_config.svh"

module cpu_datapath (
    input  logic                       clk,
    input  logic                       rst_n,
    input  lc3b_pkg::lc3b_control_word cw,
    output lc3b_pkg::lc3b_opcode       opcode,
    output logic                       ir_4,
    output logic                       ir_5,
    output logic                       ir_11,
    input  lc3b_pkg::lc3b_word         i_mem_rdata,
    output lc3b_pkg::lc3b_word         i_mem_address,
    input  lc3b_pkg::lc3b_word         d_mem_rdata,
    output lc3b_pkg::lc3b_word         d_mem_address,
    output lc3b_pkg::lc3b_word         d_mem_wdata,
    output logic                       d_mem_read,
    output logic                       d_mem_write
);

    // IF
    lc3b_pkg::lc3b_word pc, pc_plus2, pc_next;
    // ID
    lc3b_pkg::lc3b_word pc_id, ir_id, reg_a_id, reg_b_id;
    lc3b_pkg::lc3b_reg src_b_id;
    // EX
    lc3b_pkg::lc3b_control_word_ex ex_ctl;
    lc3b_pkg::lc3b_control_word_mem mem_ctl_ex;
    lc3b_pkg::lc3b_control_word_wb wb_ctl_ex;
    lc3b_pkg::lc3b_word pc_ex, reg_a_ex, reg_b_ex, alu_b, alu_f;
    lc3b_pkg::lc3b_word imm5_sext, imm4_zext, off6_adj;
    lc3b_pkg::lc3b_reg dest_ex;
    logic [10:0] ir_ex;
    // MEM
    lc3b_pkg::lc3b_control_word_mem mem_ctl;
    lc3b_pkg::lc3b_control_word_wb wb_ctl_mem;
    lc3b_pkg::lc3b_word pc_mem, alu_mem, wdata_mem;
    lc3b_pkg::lc3b_reg dest_mem;
    logic [10:0] ir_mem;
    // WB
    lc3b_pkg::lc3b_control_word_wb wb_ctl;
    lc3b_pkg::lc3b_word pc_wb, alu_wb, mdr_wb, off9_adj, off11_adj, pc_plus_off, rf_in;
    lc3b_pkg::lc3b_reg dest_wb;
    logic [10:0] ir_wb;
    logic br_enable;

    // Fetch, branch redirect comes from WB
    assign i_mem_address = pc;
    assign pc_plus2 = pc + 16'd2;
    assign pc_next = (wb_ctl.branch && br_enable) ? pc_plus_off : pc_plus2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `LC3B_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // IF/ID, instruction cleared to a NOP while in reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_id <= '0;
        end else begin
            ir_id <= i_mem_rdata;
        end
        pc_id <= pc_plus2;
    end

    assign opcode = lc3b_pkg::lc3b_opcode'(ir_id[15:12]);
    assign ir_4 = ir_id[4];
    assign ir_5 = ir_id[5];
    assign ir_11 = ir_id[11];

    // STR reads its source register through port b
    assign src_b_id = (opcode == lc3b_pkg::op_str) ? ir_id[11:9] : ir_id[2:0];

    regfile regfile_i (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (wb_ctl.load_regfile),
        .dest  (dest_wb),
        .src_a (ir_id[8:6]),
        .src_b (src_b_id),
        .in    (rf_in),
        .reg_a (reg_a_id),
        .reg_b (reg_b_id)
    );

    // ID/EX
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_ctl <= '0;
            mem_ctl_ex <= '0;
            wb_ctl_ex <= '0;
        end else begin
            ex_ctl <= cw.ex;
            mem_ctl_ex <= cw.mem;
            wb_ctl_ex <= cw.wb;
        end
        pc_ex <= pc_id;
        dest_ex <= ir_id[11:9];
        ir_ex <= ir_id[10:0];
        reg_a_ex <= reg_a_id;
        reg_b_ex <= reg_b_id;
    end

    assign imm5_sext = {{(`LC3B_WORD_W-5){ir_ex[4]}}, ir_ex[4:0]};
    assign imm4_zext = {{(`LC3B_WORD_W-4){1'b0}}, ir_ex[3:0]};
    // Word offset for LDR/STR
    assign off6_adj = {{(`LC3B_WORD_W-7){ir_ex[5]}}, ir_ex[5:0], 1'b0};

    always_comb begin
        if (ex_ctl.shamt_sel) begin
            alu_b = imm4_zext;
        end else begin
            case (ex_ctl.alumux_sel)
                lc3b_pkg::alumux_imm5: alu_b = imm5_sext;
                lc3b_pkg::alumux_off6: alu_b = off6_adj;
                default:               alu_b = reg_b_ex;
            endcase
        end
    end

    alu alu_i (
        .aluop (ex_ctl.aluop),
        .a     (reg_a_ex),
        .b     (alu_b),
        .f     (alu_f)
    );

    // EX/MEM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ctl <= '0;
            wb_ctl_mem <= '0;
        end else begin
            mem_ctl <= mem_ctl_ex;
            wb_ctl_mem <= wb_ctl_ex;
        end
        pc_mem <= pc_ex;
        dest_mem <= dest_ex;
        ir_mem <= ir_ex;
        alu_mem <= alu_f;
        wdata_mem <= reg_b_ex;
    end

    assign d_mem_address = alu_mem;
    assign d_mem_wdata = wdata_mem;
    assign d_mem_read = mem_ctl.d_mem_read;
    assign d_mem_write = mem_ctl.d_mem_write;

    // MEM/WB
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ctl <= '0;
        end else begin
            wb_ctl <= wb_ctl_mem;
        end
        pc_wb <= pc_mem;
        dest_wb <= dest_mem;
        ir_wb <= ir_mem;
        alu_wb <= alu_mem;
        mdr_wb <= d_mem_rdata;
    end

    // pc_wb already holds the instruction address plus 2
    assign off9_adj = {{(`LC3B_WORD_W-10){ir_wb[8]}}, ir_wb[8:0], 1'b0};
    assign off11_adj = {{(`LC3B_WORD_W-12){ir_wb[10]}}, ir_wb[10:0], 1'b0};
    assign pc_plus_off = pc_wb +
        ((wb_ctl.addrmux_sel == lc3b_pkg::addr_off11) ? off11_adj : off9_adj);

    always_comb begin
        case (wb_ctl.regfilemux_sel)
            lc3b_pkg::rfmux_mem:    rf_in = mdr_wb;
            lc3b_pkg::rfmux_pc_off: rf_in = pc_plus_off;
            default:                rf_in = alu_wb;
        endcase
    end

    // Branch condition bits sit in the destination field
    cc_unit cc_unit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (wb_ctl.load_cc),
        .value     (rf_in),
        .br_cond   (dest_wb),
        .br_enable (br_enable)
    );

endmodule

`default_nettype wire

/* source/lc3b_config.svh */
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// Data and address width, one word
`define LC3B_WORD_W 16

// General purpose registers R0..R7
`define LC3B_NUM_REGS 8

// First fetch address after reset
`define LC3B_RESET_PC 16'h0000

`endif

/* source/lc3b_pkg.sv */
`default_nettype none
`include "lc3b_config.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;

    // LC-3b opcode map, only part of it is executed
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass
    } lc3b_aluop;

    typedef enum logic [1:0] {
        alumux_reg,
        alumux_imm5,
        alumux_off6
    } lc3b_alumux_sel;

    typedef enum logic [1:0] {
        rfmux_alu,
        rfmux_mem,
        rfmux_pc_off
    } lc3b_rfmux_sel;

    typedef enum logic {
        addr_off9,
        addr_off11
    } lc3b_addrmux_sel;

    typedef struct packed {
        lc3b_aluop      aluop;
        lc3b_alumux_sel alumux_sel;
        logic           shamt_sel;
    } lc3b_control_word_ex;

    typedef struct packed {
        logic d_mem_read;
        logic d_mem_write;
    } lc3b_control_word_mem;

    typedef struct packed {
        logic            load_regfile;
        logic            load_cc;
        lc3b_rfmux_sel   regfilemux_sel;
        logic            branch;
        lc3b_addrmux_sel addrmux_sel;
    } lc3b_control_word_wb;

    typedef struct packed {
        lc3b_control_word_ex  ex;
        lc3b_control_word_mem mem;
        lc3b_control_word_wb  wb;
    } lc3b_control_word;

endpackage

`default_nettype wire

/* source/regfile.sv */
`default_nettype none
`include "lc3b_config.svh"

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  lc3b_pkg::lc3b_reg  dest,
    input  lc3b_pkg::lc3b_reg  src_a,
    input  lc3b_pkg::lc3b_reg  src_b,
    input  lc3b_pkg::lc3b_word in,
    output lc3b_pkg::lc3b_word reg_a,
    output lc3b_pkg::lc3b_word reg_b
);

    lc3b_pkg::lc3b_word regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // Write-through so ID sees the value WB writes in the same cycle
    assign reg_a = (load && (dest == src_a)) ? in : regs[src_a];
    assign reg_b = (load && (dest == src_b)) ? in : regs[src_b];

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/lc3b_pkg.sv
source/cpu_control.sv
source/regfile.sv
source/alu.sv
source/cc_unit.sv
source/cpu_datapath.sv
source/cpu.sv
verif/cpu_assert.sv
verif/cpu_tb.sv

/* verif/cpu_assert.sv */
`default_nettype none

module cpu_assert (
    input logic               clk,
    input logic               rst_n,
    input lc3b_pkg::lc3b_word i_mem_address,
    input lc3b_pkg::lc3b_word d_mem_address,
    input logic               d_mem_read,
    input logic               d_mem_write
);
    timeunit 1ns;
    timeprecision 1ps;

    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(d_mem_read && d_mem_write))
        else $error("read and write strobes high together");

    // Stage controls are cleared by reset
    strobe_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!d_mem_read && !d_mem_write))
        else $error("memory strobe active in the first cycle after reset");

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        i_mem_address[0] == 1'b0)
        else $error("odd instruction fetch address");

    data_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (d_mem_read || d_mem_write) |-> d_mem_address[0] == 1'b0)
        else $error("odd data address with a strobe high");

endmodule

bind cpu cpu_assert assert_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_mem_address (i_mem_address),
    .d_mem_address (d_mem_address),
    .d_mem_read    (d_mem_read),
    .d_mem_write   (d_mem_write)
);

`default_nettype wire

/* verif/cpu_patterns.hex */
// Word 0..2: program length, store count, branch check count
// 10: program, 80: data memory, A0: stores (test, addr, data), E0: (branch addr, next fetch)
@00
003E 000B 0005
@10
1227 143D 0000 0000 1642 5842 5AAC 9C7F
7600 7801 7A02 7C03 D684 D894 DBB3 6E10
7604 7805 7A06 1FE0 6211 0000 7E07 1260
E405 0000 7208 7409 0802 0000 0000 0000
0000 0206 0000 0000 0000 0000 720F 0000
5620 0406 0000 0000 0000 0000 720F 0000
983F 0606 0000 0000 0000 0000 0805 0000
0000 0000 0000 720F 780A 0000
@90
8001 1234
@A0
0001 0000 0004 0001 0002 0005 0001 0004 000C 0001 0006 FFF8
0002 0008 FFD0 0002 000A 0FFF 0002 000C FFFF
0003 000E 8001 0003 0010 1234
0004 0012 003C
0005 0014 FFFF
@E0
0038 0042 0042 0050 0052 0060 0062 006C 006C 0078

/* verif/cpu_tb.sv */
`default_nettype none
`include "lc3b_config.svh"

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // Word offsets of the pattern image regions
    localparam int PAT_WORDS = 256;
    localparam int PROG_BASE = 'h10;
    localparam int DATA_BASE = 'h80;
    localparam int DATA_WORDS = 32;
    localparam int STORE_BASE = 'hA0;
    localparam int FETCH_BASE = 'hE0;

    logic clk;
    logic rst_n;
    lc3b_pkg::lc3b_word i_mem_rdata;
    lc3b_pkg::lc3b_word i_mem_address;
    lc3b_pkg::lc3b_word d_mem_rdata;
    lc3b_pkg::lc3b_word d_mem_address;
    lc3b_pkg::lc3b_word d_mem_wdata;
    logic d_mem_read;
    logic d_mem_write;

    lc3b_pkg::lc3b_word pats [PAT_WORDS];
    lc3b_pkg::lc3b_word dmem [DATA_WORDS];
    lc3b_pkg::lc3b_word fetch_expect [$];
    int fetch_due [$];
    int test_errors [1:6];
    int prog_len = 0;
    int store_total = 0;
    int fetch_total = 0;
    int store_idx = 0;
    int fetch_idx = 0;
    int cyc = 0;
    int first_str_cycle = 0;
    int errors_total = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    bit reset_checked = 1'b0;

    cpu dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_mem_rdata   (i_mem_rdata),
        .i_mem_address (i_mem_address),
        .d_mem_rdata   (d_mem_rdata),
        .d_mem_address (d_mem_address),
        .d_mem_wdata   (d_mem_wdata),
        .d_mem_read    (d_mem_read),
        .d_mem_write   (d_mem_write)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Outside the program the fetch returns NOPs
    function automatic lc3b_pkg::lc3b_word fetch_word(input lc3b_pkg::lc3b_word addr);
        int idx;
        idx = int'(addr[15:1]);
        if (idx < prog_len) begin
            return pats[PROG_BASE + idx];
        end
        return 16'h0000;
    endfunction

    always_comb i_mem_rdata = fetch_word(i_mem_address);

    // Data memory only answers while the read strobe is high
    always_comb d_mem_rdata = d_mem_read ? dmem[int'(d_mem_address[5:1])] : 16'h0000;

    function automatic string test_name(input int tid);
        case (tid)
            1: return "add, and, not";
            2: return "shifts";
            3: return "ldr";
            4: return "lea";
            5: return "branches";
            default: return "reset";
        endcase
    endfunction

    task automatic note_error(input int tid);
        test_errors[tid]++;
        errors_total++;
    endtask

    task automatic report_test(input int tid);
        if (test_errors[tid] == 0) begin
            tests_passed++;
            $display("Test %0d (%s): passed", tid, test_name(tid));
        end else begin
            tests_failed++;
            $display("Test %0d (%s): FAILED, %0d mismatches", tid, test_name(tid),
                     test_errors[tid]);
        end
    endtask

    task automatic check_store(input lc3b_pkg::lc3b_word addr, input lc3b_pkg::lc3b_word data);
        int tid;
        lc3b_pkg::lc3b_word exp_addr;
        lc3b_pkg::lc3b_word exp_data;
        if (store_idx >= store_total) begin
            $display("Unexpected store of %h to address %h after the last expected store",
                     data, addr);
            errors_total++;
            return;
        end
        tid = int'(pats[STORE_BASE + 3 * store_idx]);
        exp_addr = pats[STORE_BASE + 3 * store_idx + 1];
        exp_data = pats[STORE_BASE + 3 * store_idx + 2];
        if (addr !== exp_addr || data !== exp_data) begin
            $display("CHECK FAILED at %0t: store %0d wrote %h to %h, expected %h to %h",
                     $time, store_idx, data, addr, exp_data, exp_addr);
            note_error(tid);
        end
        store_idx++;
        if (store_idx == store_total || int'(pats[STORE_BASE + 3 * store_idx]) != tid) begin
            report_test(tid);
        end
    endtask

    task automatic check_fetch(input lc3b_pkg::lc3b_word addr);
        lc3b_pkg::lc3b_word exp_addr;
        exp_addr = fetch_expect.pop_front();
        if (addr !== exp_addr) begin
            $display("CHECK FAILED at %0t: fetch after branch %0d at %h, expected %h",
                     $time, fetch_idx, addr, exp_addr);
            note_error(5);
        end
        fetch_idx++;
    endtask

    // Pipeline monitor sees the values of the cycle that just ended
    always @(posedge clk) begin
        if (rst_n) begin
            if (cyc == 0 && i_mem_address !== `LC3B_RESET_PC) begin
                $display("CHECK FAILED at %0t: first fetch at %h, expected %h",
                         $time, i_mem_address, `LC3B_RESET_PC);
                note_error(6);
            end
            if (d_mem_write) begin
                if (cyc < first_str_cycle) begin
                    $display("Write strobe in cycle %0d, before the first STR reached MEM", cyc);
                    note_error(6);
                end
                dmem[int'(d_mem_address[5:1])] <= d_mem_wdata;
                check_store(d_mem_address, d_mem_wdata);
            end
            if (fetch_due.size() > 0 && fetch_due[0] == cyc) begin
                void'(fetch_due.pop_front());
                check_fetch(i_mem_address);
            end
            // Redirect shows five cycles after the branch is fetched
            for (int k = 0; k < fetch_total; k++) begin
                if (i_mem_address == pats[FETCH_BASE + 2 * k]) begin
                    fetch_due.push_back(cyc + 5);
                    fetch_expect.push_back(pats[FETCH_BASE + 2 * k + 1]);
                end
            end
            if (cyc == first_str_cycle) begin
                report_test(6);
                reset_checked = 1'b1;
            end
            cyc = cyc + 1;
        end
    end

    initial begin
        rst_n = 1'b0;
        for (int i = 1; i <= 6; i++) begin
            test_errors[i] = 0;
        end
        for (int i = 0; i < PAT_WORDS; i++) begin
            pats[i] = lc3b_pkg::lc3b_word'(i * 257) ^ 16'h5a00;
        end
        $readmemh("verif/cpu_patterns.hex", pats);
        for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i] = pats[DATA_BASE + i];
        end
        store_total = int'(pats[1]);
        fetch_total = int'(pats[2]);
        for (int i = int'(pats[0]) - 1; i >= 0; i--) begin
            if (pats[PROG_BASE + i][15:12] == 4'b0111) begin
                first_str_cycle = i + 3;
            end
        end
        prog_len = int'(pats[0]);
        if (prog_len == 0) begin
            $display("The pattern file holds no program");
            $display("Errors found");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            wait (store_idx == store_total && fetch_idx == fetch_total && reset_checked);
            @(posedge clk);
            $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                     tests_passed, tests_failed, errors_total);
            if (errors_total == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

    initial begin
        wait (prog_len > 0);
        #(prog_len * 10 + 200);
        $display("The run timed out after %0d stores and %0d branch checks", store_idx, fetch_idx);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
